/* excl_pkg.sv */
package excl_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [3:0]  id_t;
    typedef logic [1:0]  resp_t;

    // AXI response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_EXOKAY = 2'b01;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    ////////////////////
    // Channel payloads
    ////////////////////

    typedef struct packed {
        id_t        id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
        logic       lock;
    } axi_ar_t;

    // Same layout as AR
    typedef struct packed {
        id_t        id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
        logic       lock;
    } axi_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } axi_b_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } axi_r_t;

    // Exclusive monitor FSM
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } excl_state_e;

endpackage

/* axi_excl_monitor.sv */
`timescale 1ns/1ns

module axi_excl_monitor
    import excl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    // CPU side, AXI4 slave
    input  axi_ar_t cpu_ar,
    input  logic    cpu_ar_valid,
    output logic    cpu_ar_ready,
    input  axi_aw_t cpu_aw,
    input  logic    cpu_aw_valid,
    output logic    cpu_aw_ready,
    input  axi_w_t  cpu_w,
    input  logic    cpu_w_valid,
    output logic    cpu_w_ready,
    output axi_b_t  cpu_b,
    output logic    cpu_b_valid,
    input  logic    cpu_b_ready,
    output axi_r_t  cpu_r,
    output logic    cpu_r_valid,
    input  logic    cpu_r_ready,

    // Memory side, AXI4 master
    output axi_ar_t mem_ar,
    output logic    mem_ar_valid,
    input  logic    mem_ar_ready,
    output axi_aw_t mem_aw,
    output logic    mem_aw_valid,
    input  logic    mem_aw_ready,
    output axi_w_t  mem_w,
    output logic    mem_w_valid,
    input  logic    mem_w_ready,
    input  axi_b_t  mem_b,
    input  logic    mem_b_valid,
    output logic    mem_b_ready,
    input  axi_r_t  mem_r,
    input  logic    mem_r_valid,
    output logic    mem_r_ready
);

    excl_state_e state;
    logic        ar_done;
    logic        aw_done;
    logic        w_done;

    // Current transaction
    logic        cur_lock;
    logic        cur_atomic_err;
    addr_t       cur_addr;

    // Single reservation
    logic        resv_valid;
    addr_t       resv_addr;

    logic        rd_sel;
    logic        wr_sel;
    logic        aw_err;
    logic        sc_fail;
    logic        ar_hs;
    logic        aw_hs;
    logic        w_hs;
    logic        r_hs;
    logic        b_hs;

    // A pending read wins over a pending write in IDLE
    assign rd_sel = (state == READ) || (state == IDLE && cpu_ar_valid);
    assign wr_sel = (state == WRITE) || (state == IDLE && !cpu_ar_valid && cpu_aw_valid);

    ////////////////////
    // Read path
    ////////////////////

    assign mem_ar_valid = rd_sel && !ar_done && cpu_ar_valid;
    assign cpu_ar_ready = rd_sel && !ar_done && mem_ar_ready;

    always_comb begin
        mem_ar      = cpu_ar;
        // Memory does not see the lock bit
        mem_ar.lock = 1'b0;
    end

    assign cpu_r_valid = (state == READ) && ar_done && mem_r_valid;
    assign mem_r_ready = (state == READ) && ar_done && cpu_r_ready;

    always_comb begin
        cpu_r = mem_r;
        // Error responses pass through untouched
        if (cur_lock && mem_r.resp == RESP_OKAY) begin
            cpu_r.resp = RESP_EXOKAY;
        end
    end

    ////////////////////
    // Write path
    ////////////////////

    // Store-conditional fails without a matching reservation
    assign aw_err  = cpu_aw.lock && !(resv_valid && resv_addr == cpu_aw.addr);
    assign sc_fail = aw_done ? cur_atomic_err : aw_err;

    assign mem_aw_valid = wr_sel && !aw_done && cpu_aw_valid;
    assign cpu_aw_ready = wr_sel && !aw_done && mem_aw_ready;

    always_comb begin
        mem_aw      = cpu_aw;
        mem_aw.lock = 1'b0;
    end

    assign mem_w_valid = wr_sel && !w_done && cpu_w_valid;
    assign cpu_w_ready = wr_sel && !w_done && mem_w_ready;

    always_comb begin
        mem_w = cpu_w;
        // Failed SC still reaches memory but writes nothing
        if (sc_fail) begin
            mem_w.strb = '0;
        end
    end

    assign cpu_b_valid = (state == WRITE) && aw_done && w_done && mem_b_valid;
    assign mem_b_ready = (state == WRITE) && aw_done && w_done && cpu_b_ready;

    always_comb begin
        cpu_b = mem_b;
        if (cur_lock && !cur_atomic_err && mem_b.resp == RESP_OKAY) begin
            cpu_b.resp = RESP_EXOKAY;
        end
    end

    assign ar_hs = mem_ar_valid && mem_ar_ready;
    assign aw_hs = mem_aw_valid && mem_aw_ready;
    assign w_hs  = mem_w_valid && mem_w_ready;
    assign r_hs  = cpu_r_valid && cpu_r_ready;
    assign b_hs  = cpu_b_valid && cpu_b_ready;

    ////////////////////
    // Control state
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= IDLE;
            ar_done        <= 1'b0;
            aw_done        <= 1'b0;
            w_done         <= 1'b0;
            cur_lock       <= 1'b0;
            cur_atomic_err <= 1'b0;
            resv_valid     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_ar_valid) begin
                        state <= READ;
                    end else if (cpu_aw_valid) begin
                        state <= WRITE;
                    end
                end
                READ: begin
                    if (r_hs) begin
                        state <= IDLE;
                    end
                end
                WRITE: begin
                    if (b_hs) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (ar_hs) begin
                ar_done  <= 1'b1;
                cur_lock <= cpu_ar.lock;
            end else if (aw_hs) begin
                cur_lock       <= cpu_aw.lock;
                cur_atomic_err <= aw_err;
            end

            if (aw_hs) begin
                aw_done <= 1'b1;
            end else if (b_hs) begin
                aw_done <= 1'b0;
            end

            if (w_hs) begin
                w_done <= 1'b1;
            end else if (b_hs) begin
                w_done <= 1'b0;
            end

            if (r_hs) begin
                ar_done <= 1'b0;
            end

            // Reservation changes only when the response is handed over
            if (r_hs && cur_lock) begin
                resv_valid <= 1'b1;
            end else if (b_hs && resv_valid && resv_addr == cur_addr) begin
                resv_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            cur_addr <= cpu_ar.addr;
        end else if (aw_hs) begin
            cur_addr <= cpu_aw.addr;
        end
        if (r_hs && cur_lock) begin
            resv_addr <= cur_addr;
        end
    end

endmodule

/* axi_sram.sv */
`timescale 1ns/1ns

module axi_sram
    import excl_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst_n,

    input  axi_ar_t mem_ar,
    input  logic    mem_ar_valid,
    output logic    mem_ar_ready,
    input  axi_aw_t mem_aw,
    input  logic    mem_aw_valid,
    output logic    mem_aw_ready,
    input  axi_w_t  mem_w,
    input  logic    mem_w_valid,
    output logic    mem_w_ready,
    output axi_b_t  mem_b,
    output logic    mem_b_valid,
    input  logic    mem_b_ready,
    output axi_r_t  mem_r,
    output logic    mem_r_valid,
    input  logic    mem_r_ready
);

    localparam int IDX_W  = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int STRB_W = $bits(strb_t);

    data_t            mem [MEM_WORDS];

    logic             r_pend;
    logic             b_pend;
    axi_r_t           r_q;
    axi_b_t           b_q;
    logic             busy;
    logic             rd_go;
    logic             wr_go;

    logic [29:0]      ar_word;
    logic [29:0]      aw_word;
    logic             ar_in_range;
    logic             aw_in_range;
    logic [IDX_W-1:0] ar_idx;
    logic [IDX_W-1:0] aw_idx;

    // Word index is the byte address divided by four
    assign ar_word     = mem_ar.addr[31:2];
    assign aw_word     = mem_aw.addr[31:2];
    assign ar_in_range = ar_word < 30'(MEM_WORDS);
    assign aw_in_range = aw_word < 30'(MEM_WORDS);
    assign ar_idx      = ar_word[IDX_W-1:0];
    assign aw_idx      = aw_word[IDX_W-1:0];

    ////////////////////
    // Request acceptance
    ////////////////////

    // Nothing new while a response is still waiting
    assign busy = r_pend || b_pend;

    // AW and W go in together, reads take priority
    assign mem_ar_ready = !busy;
    assign mem_aw_ready = !busy && !mem_ar_valid && mem_w_valid;
    assign mem_w_ready  = !busy && !mem_ar_valid && mem_aw_valid;

    assign rd_go = mem_ar_valid && mem_ar_ready;
    assign wr_go = mem_aw_valid && mem_aw_ready;

    assign mem_r_valid = r_pend;
    assign mem_r       = r_q;
    assign mem_b_valid = b_pend;
    assign mem_b       = b_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_pend <= 1'b0;
            b_pend <= 1'b0;
        end else begin
            if (rd_go) begin
                r_pend <= 1'b1;
            end else if (r_pend && mem_r_ready) begin
                r_pend <= 1'b0;
            end
            if (wr_go) begin
                b_pend <= 1'b1;
            end else if (b_pend && mem_b_ready) begin
                b_pend <= 1'b0;
            end
        end
    end

    ////////////////////
    // Response payloads
    ////////////////////

    always_ff @(posedge clk) begin
        if (rd_go) begin
            r_q.id   <= mem_ar.id;
            r_q.data <= ar_in_range ? mem[ar_idx] : '0;
            r_q.resp <= ar_in_range ? RESP_OKAY : RESP_DECERR;
            r_q.last <= 1'b1;
        end
        if (wr_go) begin
            b_q.id   <= mem_aw.id;
            b_q.resp <= aw_in_range ? RESP_OKAY : RESP_DECERR;
        end
    end

    // Byte lanes, out-of-range writes are dropped
    always_ff @(posedge clk) begin
        if (wr_go && aw_in_range) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (mem_w.strb[i]) begin
                    mem[aw_idx][8*i +: 8] <= mem_w.data[8*i +: 8];
                end
            end
        end
    end

endmodule

/* excl_mem_top.sv */
`timescale 1ns/1ns

module excl_mem_top
    import excl_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst_n,

    input  axi_aw_t cpu_aw,
    input  logic    cpu_aw_valid,
    output logic    cpu_aw_ready,
    input  axi_w_t  cpu_w,
    input  logic    cpu_w_valid,
    output logic    cpu_w_ready,
    output axi_b_t  cpu_b,
    output logic    cpu_b_valid,
    input  logic    cpu_b_ready,
    input  axi_ar_t cpu_ar,
    input  logic    cpu_ar_valid,
    output logic    cpu_ar_ready,
    output axi_r_t  cpu_r,
    output logic    cpu_r_valid,
    input  logic    cpu_r_ready
);

    // Monitor to memory
    axi_ar_t mem_ar;
    logic    mem_ar_valid;
    logic    mem_ar_ready;
    axi_aw_t mem_aw;
    logic    mem_aw_valid;
    logic    mem_aw_ready;
    axi_w_t  mem_w;
    logic    mem_w_valid;
    logic    mem_w_ready;
    axi_b_t  mem_b;
    logic    mem_b_valid;
    logic    mem_b_ready;
    axi_r_t  mem_r;
    logic    mem_r_valid;
    logic    mem_r_ready;

    axi_excl_monitor u_monitor (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_ar       (cpu_ar),
        .cpu_ar_valid (cpu_ar_valid),
        .cpu_ar_ready (cpu_ar_ready),
        .cpu_aw       (cpu_aw),
        .cpu_aw_valid (cpu_aw_valid),
        .cpu_aw_ready (cpu_aw_ready),
        .cpu_w        (cpu_w),
        .cpu_w_valid  (cpu_w_valid),
        .cpu_w_ready  (cpu_w_ready),
        .cpu_b        (cpu_b),
        .cpu_b_valid  (cpu_b_valid),
        .cpu_b_ready  (cpu_b_ready),
        .cpu_r        (cpu_r),
        .cpu_r_valid  (cpu_r_valid),
        .cpu_r_ready  (cpu_r_ready),
        .mem_ar       (mem_ar),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar_ready (mem_ar_ready),
        .mem_aw       (mem_aw),
        .mem_aw_valid (mem_aw_valid),
        .mem_aw_ready (mem_aw_ready),
        .mem_w        (mem_w),
        .mem_w_valid  (mem_w_valid),
        .mem_w_ready  (mem_w_ready),
        .mem_b        (mem_b),
        .mem_b_valid  (mem_b_valid),
        .mem_b_ready  (mem_b_ready),
        .mem_r        (mem_r),
        .mem_r_valid  (mem_r_valid),
        .mem_r_ready  (mem_r_ready)
    );

    axi_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_ar       (mem_ar),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar_ready (mem_ar_ready),
        .mem_aw       (mem_aw),
        .mem_aw_valid (mem_aw_valid),
        .mem_aw_ready (mem_aw_ready),
        .mem_w        (mem_w),
        .mem_w_valid  (mem_w_valid),
        .mem_w_ready  (mem_w_ready),
        .mem_b        (mem_b),
        .mem_b_valid  (mem_b_valid),
        .mem_b_ready  (mem_b_ready),
        .mem_r        (mem_r),
        .mem_r_valid  (mem_r_valid),
        .mem_r_ready  (mem_r_ready)
    );

endmodule

/* excl_monitor_props.sv */
`timescale 1ns/1ns

module excl_monitor_props
    import excl_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input excl_state_e state,
    input axi_ar_t     cpu_ar,
    input logic        cpu_ar_valid,
    input logic        cpu_ar_ready,
    input axi_aw_t     cpu_aw,
    input logic        cpu_aw_valid,
    input logic        cpu_aw_ready,
    input axi_r_t      cpu_r,
    input logic        cpu_r_valid,
    input logic        cpu_r_ready,
    input axi_b_t      cpu_b,
    input logic        cpu_b_valid,
    input logic        cpu_b_ready,
    input axi_w_t      mem_w,
    input logic        mem_w_valid
);

    int    fail_count = 0;
    logic  sc_no_match;

    // Reservation rebuilt from the CPU-side handshakes
    logic  shadow_valid;
    addr_t shadow_addr;
    logic  rd_lock;
    addr_t rd_addr;
    addr_t wr_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow_valid <= 1'b0;
            rd_lock      <= 1'b0;
        end else begin
            if (cpu_ar_valid && cpu_ar_ready) begin
                rd_lock <= cpu_ar.lock;
                rd_addr <= cpu_ar.addr;
            end
            if (cpu_aw_valid && cpu_aw_ready) begin
                wr_addr <= cpu_aw.addr;
            end
            if (cpu_r_valid && cpu_r_ready && rd_lock) begin
                shadow_valid <= 1'b1;
                shadow_addr  <= rd_addr;
            end else if (cpu_b_valid && cpu_b_ready && shadow_valid && shadow_addr == wr_addr) begin
                shadow_valid <= 1'b0;
            end
        end
    end

    // Locked write without a reservation on its own address
    assign sc_no_match = cpu_aw_valid && cpu_aw.lock &&
                         !(shadow_valid && shadow_addr == cpu_aw.addr);

    one_resp_at_a_time: assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_r_valid && cpu_b_valid))
        else begin
            $error("R and B responses valid in the same cycle");
            fail_count++;
        end

    r_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_r_valid && !cpu_r_ready |=> cpu_r_valid && $stable(cpu_r))
        else begin
            $error("R payload changed while stalled");
            fail_count++;
        end

    b_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_b_valid && !cpu_b_ready |=> cpu_b_valid && $stable(cpu_b))
        else begin
            $error("B payload changed while stalled");
            fail_count++;
        end

    failed_sc_no_strobes: assert property (@(posedge clk) disable iff (!rst_n)
        mem_w_valid && sc_no_match |-> mem_w.strb == '0)
        else begin
            $error("Failed store-conditional reached memory with strobes set");
            fail_count++;
        end

    r_only_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_r_valid |-> state == READ)
        else begin
            $error("R valid outside state READ");
            fail_count++;
        end

endmodule

bind axi_excl_monitor excl_monitor_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .state          (state),
    .cpu_ar         (cpu_ar),
    .cpu_ar_valid   (cpu_ar_valid),
    .cpu_ar_ready   (cpu_ar_ready),
    .cpu_aw         (cpu_aw),
    .cpu_aw_valid   (cpu_aw_valid),
    .cpu_aw_ready   (cpu_aw_ready),
    .cpu_r          (cpu_r),
    .cpu_r_valid    (cpu_r_valid),
    .cpu_r_ready    (cpu_r_ready),
    .cpu_b          (cpu_b),
    .cpu_b_valid    (cpu_b_valid),
    .cpu_b_ready    (cpu_b_ready),
    .mem_w          (mem_w),
    .mem_w_valid    (mem_w_valid)
);

/* excl_checker.sv */
`timescale 1ns/1ns

module excl_checker
    import excl_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst_n,
    input  axi_aw_t cpu_aw,
    input  logic    cpu_aw_valid,
    input  logic    cpu_aw_ready,
    input  axi_w_t  cpu_w,
    input  logic    cpu_w_valid,
    input  logic    cpu_w_ready,
    input  axi_b_t  cpu_b,
    input  logic    cpu_b_valid,
    input  logic    cpu_b_ready,
    input  axi_ar_t cpu_ar,
    input  logic    cpu_ar_valid,
    input  logic    cpu_ar_ready,
    input  axi_r_t  cpu_r,
    input  logic    cpu_r_valid,
    input  logic    cpu_r_ready,
    output int      resp_errs,
    output int      data_errs,
    output int      n_checked
);

    typedef struct packed {
        id_t   id;
        resp_t resp;
        data_t data;
    } expect_t;

    ////////////////////
    // Reference model
    ////////////////////

    data_t   model_mem [MEM_WORDS];
    logic    model_resv_valid;
    addr_t   model_resv_addr;

    expect_t rd_q[$];
    expect_t wr_q[$];
    axi_aw_t aw_hold;
    axi_w_t  w_hold;
    logic    aw_seen;
    logic    w_seen;
    expect_t exp;

    function automatic expect_t expect_resp(input logic is_write, input addr_t addr,
                                            input data_t wdata, input strb_t strb,
                                            input logic lock);
        expect_t     res;
        int unsigned idx;
        logic        in_range;
        logic        sc_ok;
        res      = '0;
        idx      = {2'b00, addr[31:2]};
        in_range = idx < MEM_WORDS;
        if (!is_write) begin
            if (!in_range) begin
                res.resp = RESP_DECERR;
            end else begin
                res.data = model_mem[idx];
                res.resp = lock ? RESP_EXOKAY : RESP_OKAY;
            end
            // Any locked read takes the single reservation
            if (lock) begin
                model_resv_valid = 1'b1;
                model_resv_addr  = addr;
            end
        end else begin
            sc_ok = !lock || (model_resv_valid && model_resv_addr == addr);
            if (!in_range) begin
                res.resp = RESP_DECERR;
            end else begin
                res.resp = (lock && sc_ok) ? RESP_EXOKAY : RESP_OKAY;
                if (sc_ok) begin
                    for (int b = 0; b < 4; b++) begin
                        if (strb[b]) begin
                            model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
                        end
                    end
                end
            end
            // Any write to the reserved address ends the reservation
            if (model_resv_valid && model_resv_addr == addr) begin
                model_resv_valid = 1'b0;
            end
        end
        return res;
    endfunction

    ////////////////////
    // Compare
    ////////////////////

    always @(posedge clk) begin
        if (!rst_n) begin
            model_resv_valid = 1'b0;
            aw_seen          = 1'b0;
            w_seen           = 1'b0;
        end else begin
            if (cpu_b_valid && cpu_b_ready) begin
                if (wr_q.size() == 0) begin
                    $display("write response at %0t with no write outstanding", $time);
                    resp_errs++;
                end else begin
                    exp = wr_q.pop_front();
                    n_checked++;
                    if (cpu_b.id !== exp.id || cpu_b.resp !== exp.resp) begin
                        $display("error %0t: write id %0h resp %0h, expected id %0h resp %0h",
                                 $time, cpu_b.id, cpu_b.resp, exp.id, exp.resp);
                        resp_errs++;
                    end
                end
            end

            if (cpu_r_valid && cpu_r_ready) begin
                if (rd_q.size() == 0) begin
                    $display("read response at %0t with no read outstanding", $time);
                    resp_errs++;
                end else begin
                    exp = rd_q.pop_front();
                    n_checked++;
                    if (cpu_r.id !== exp.id || cpu_r.resp !== exp.resp || cpu_r.last !== 1'b1) begin
                        $display("error %0t: read id %0h resp %0h last %0b, expected id %0h resp %0h",
                                 $time, cpu_r.id, cpu_r.resp, cpu_r.last, exp.id, exp.resp);
                        resp_errs++;
                    end
                    if (cpu_r.data !== exp.data) begin
                        $display("error %0t: read data %08h, expected %08h",
                                 $time, cpu_r.data, exp.data);
                        data_errs++;
                    end
                end
            end

            // Requests update the model as they are accepted
            if (cpu_ar_valid && cpu_ar_ready) begin
                exp    = expect_resp(1'b0, cpu_ar.addr, '0, '0, cpu_ar.lock);
                exp.id = cpu_ar.id;
                rd_q.push_back(exp);
            end
            if (cpu_aw_valid && cpu_aw_ready) begin
                aw_hold = cpu_aw;
                aw_seen = 1'b1;
            end
            if (cpu_w_valid && cpu_w_ready) begin
                w_hold = cpu_w;
                w_seen = 1'b1;
            end
            if (aw_seen && w_seen) begin
                exp     = expect_resp(1'b1, aw_hold.addr, w_hold.data, w_hold.strb, aw_hold.lock);
                exp.id  = aw_hold.id;
                wr_q.push_back(exp);
                aw_seen = 1'b0;
                w_seen  = 1'b0;
            end
        end
    end

endmodule

/* tb_excl_top.sv */
`timescale 1ns/1ns

module tb_excl_top
    import excl_pkg::*;
();

    localparam int MEM_WORDS  = 256;
    localparam int WORK_WORDS = 16;
    localparam int N_PLAIN    = 24;
    localparam int N_DIRECTED = 23;
    localparam int N_RANDOM   = 400;
    localparam int N_TXN      = WORK_WORDS + 2 * N_PLAIN + N_DIRECTED + N_RANDOM;

    logic    clk;
    logic    rst_n;
    axi_aw_t cpu_aw;
    logic    cpu_aw_valid;
    logic    cpu_aw_ready;
    axi_w_t  cpu_w;
    logic    cpu_w_valid;
    logic    cpu_w_ready;
    axi_b_t  cpu_b;
    logic    cpu_b_valid;
    logic    cpu_b_ready;
    axi_ar_t cpu_ar;
    logic    cpu_ar_valid;
    logic    cpu_ar_ready;
    axi_r_t  cpu_r;
    logic    cpu_r_valid;
    logic    cpu_r_ready;

    int      resp_errs;
    int      data_errs;
    int      n_checked;
    int      prop_fails;
    int      issued;
    id_t     next_id;

    excl_mem_top #(
        .MEM_WORDS (MEM_WORDS)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_aw       (cpu_aw),
        .cpu_aw_valid (cpu_aw_valid),
        .cpu_aw_ready (cpu_aw_ready),
        .cpu_w        (cpu_w),
        .cpu_w_valid  (cpu_w_valid),
        .cpu_w_ready  (cpu_w_ready),
        .cpu_b        (cpu_b),
        .cpu_b_valid  (cpu_b_valid),
        .cpu_b_ready  (cpu_b_ready),
        .cpu_ar       (cpu_ar),
        .cpu_ar_valid (cpu_ar_valid),
        .cpu_ar_ready (cpu_ar_ready),
        .cpu_r        (cpu_r),
        .cpu_r_valid  (cpu_r_valid),
        .cpu_r_ready  (cpu_r_ready)
    );

    excl_checker #(
        .MEM_WORDS (MEM_WORDS)
    ) u_checker (.*);

    always #10 clk = ~clk;

    function automatic addr_t word_addr(input int unsigned idx);
        return idx << 2;
    endfunction

    ////////////////////
    // Bus tasks
    ////////////////////

    task automatic write_word(input addr_t addr, input data_t data, input strb_t strb,
                              input logic lock);
        int unsigned stall;
        logic        aw_open;
        logic        w_open;
        stall        = $urandom_range(3, 0);
        cpu_aw       = '{id: next_id, addr: addr, len: 8'd0, size: 3'd2, burst: 2'b01, lock: lock};
        cpu_w        = '{data: data, strb: strb, last: 1'b1};
        cpu_aw_valid = 1'b1;
        cpu_w_valid  = 1'b1;
        aw_open      = 1'b1;
        w_open       = 1'b1;
        next_id      = next_id + 4'd1;
        issued++;
        while (aw_open || w_open) begin
            @(posedge clk);
            if (cpu_aw_valid && cpu_aw_ready) begin
                aw_open = 1'b0;
            end
            if (cpu_w_valid && cpu_w_ready) begin
                w_open = 1'b0;
            end
            #2;
            cpu_aw_valid = aw_open;
            cpu_w_valid  = w_open;
        end
        // Back-pressure on B
        repeat (stall) begin
            @(posedge clk);
            #2;
        end
        cpu_b_ready = 1'b1;
        @(posedge clk);
        while (!cpu_b_valid) begin
            @(posedge clk);
        end
        #2;
        cpu_b_ready = 1'b0;
    endtask

    task automatic read_word(input addr_t addr, input logic lock);
        int unsigned stall;
        stall        = $urandom_range(3, 0);
        cpu_ar       = '{id: next_id, addr: addr, len: 8'd0, size: 3'd2, burst: 2'b01, lock: lock};
        cpu_ar_valid = 1'b1;
        next_id      = next_id + 4'd1;
        issued++;
        @(posedge clk);
        while (!cpu_ar_ready) begin
            @(posedge clk);
        end
        #2;
        cpu_ar_valid = 1'b0;
        repeat (stall) begin
            @(posedge clk);
            #2;
        end
        cpu_r_ready = 1'b1;
        @(posedge clk);
        while (!cpu_r_valid) begin
            @(posedge clk);
        end
        #2;
        cpu_r_ready = 1'b0;
    endtask

    // Mostly a few hot words so reservations get hit, sometimes out of range
    task automatic random_access();
        addr_t       addr;
        int unsigned op;
        if ($urandom_range(7, 0) == 0) begin
            addr = word_addr(MEM_WORDS + $urandom_range(3, 0));
        end else begin
            addr = word_addr($urandom_range(3, 0));
        end
        op = $urandom_range(3, 0);
        case (op)
            0: read_word(addr, 1'b0);
            1: read_word(addr, 1'b1);
            2: write_word(addr, $urandom, strb_t'($urandom), 1'b0);
            default: write_word(addr, $urandom, strb_t'($urandom), 1'b1);
        endcase
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        addr_t addr;
        int    total_errs;
        void'($urandom(32'hdf00));
        clk          = 1'b0;
        rst_n        = 1'b0;
        cpu_aw       = '0;
        cpu_aw_valid = 1'b0;
        cpu_w        = '0;
        cpu_w_valid  = 1'b0;
        cpu_b_ready  = 1'b0;
        cpu_ar       = '0;
        cpu_ar_valid = 1'b0;
        cpu_r_ready  = 1'b0;
        next_id      = '0;
        issued       = 0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Known contents for the working words
        for (int i = 0; i < WORK_WORDS; i++) begin
            write_word(word_addr(i), $urandom, 4'hf, 1'b0);
        end

        // Plain writes with random strobes, read back
        for (int i = 0; i < N_PLAIN; i++) begin
            addr = word_addr($urandom_range(WORK_WORDS - 1, 0));
            write_word(addr, $urandom, strb_t'($urandom), 1'b0);
            read_word(addr, 1'b0);
        end

        // Successful load-reserved / store-conditional pair
        read_word(word_addr(3), 1'b1);
        write_word(word_addr(3), 32'h1234_5678, 4'hf, 1'b1);
        read_word(word_addr(3), 1'b0);

        // SC with no reservation, then SC to another address
        write_word(word_addr(5), 32'hdead_beef, 4'hf, 1'b1);
        read_word(word_addr(5), 1'b0);
        read_word(word_addr(6), 1'b1);
        write_word(word_addr(7), 32'hcafe_f00d, 4'hf, 1'b1);
        read_word(word_addr(7), 1'b0);

        // Plain write breaks the reservation, a new LR moves it
        read_word(word_addr(8), 1'b1);
        write_word(word_addr(8), 32'h0bad_cafe, 4'hf, 1'b0);
        write_word(word_addr(8), 32'h5555_aaaa, 4'hf, 1'b1);
        read_word(word_addr(8), 1'b0);
        read_word(word_addr(9), 1'b1);
        read_word(word_addr(10), 1'b1);
        write_word(word_addr(9), 32'h1111_2222, 4'hf, 1'b1);
        write_word(word_addr(10), 32'h3333_4444, 4'hf, 1'b1);
        read_word(word_addr(10), 1'b0);

        // Past the end of memory
        write_word(word_addr(MEM_WORDS), $urandom, 4'hf, 1'b0);
        read_word(word_addr(MEM_WORDS), 1'b0);
        read_word(word_addr(MEM_WORDS + 7), 1'b1);
        write_word(word_addr(MEM_WORDS + 7), $urandom, 4'hf, 1'b1);
        write_word(32'hffff_fffc, $urandom, 4'hf, 1'b1);
        read_word(32'hffff_fffc, 1'b1);

        for (int i = 0; i < N_RANDOM; i++) begin
            random_access();
        end

        repeat (2) @(posedge clk);
        prop_fails = DUT.u_monitor.u_props.fail_count;
        total_errs = resp_errs + data_errs + prop_fails;
        if (n_checked != issued) begin
            $display("only %0d of %0d responses were checked", n_checked, issued);
            total_errs++;
        end
        $display("results: %0d checked, %0d response errors, %0d data errors, %0d assertion errors",
                 n_checked, resp_errs, data_errs, prop_fails);
        if (total_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (200 * N_TXN) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", 200 * N_TXN);
        $display("tests failed");
        $finish;
    end

endmodule

/* files.f */
excl_pkg.sv
axi_excl_monitor.sv
axi_sram.sv
excl_mem_top.sv
excl_monitor_props.sv
excl_checker.sv
tb_excl_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_excl_top
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM_FLAGS := +verilator+error+limit+1000
LOG       := sim.log
FAIL_MSG  := tests failed
PASS_MSG  := all tests passed
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(BIN) $(SIM_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
